/* design/rfo_defs.svh */
`ifndef RFO_DEFS_SVH
`define RFO_DEFS_SVH

// iq delay line length, must stay a power of two
`define RFO_DELAY_DEPTH 256
// in-phase tap, in 10 MHz samples
`define RFO_PHASE_TAP 37
// quarter period tap, in 10 MHz samples
`define RFO_QUAD_TAP 79

// lock hysteresis on |theta|
// lock lost at or above this
`define RFO_LOCK_UPPER 40
// lock gained below this
`define RFO_LOCK_LOWER 16

// strobe divisors, in clocks
`define RFO_AVG_DIV 4000
`define RFO_LOCK_DIV 16000
`define RFO_CTRL_DIV 32000

// oscillator increment out of reset
`define RFO_START_POINT 24140
// added during high half of dither phase
`define RFO_DITHER_STEP 256

`endif

/* design/phase_types_pkg.sv */
`default_nettype none

package phase_types_pkg;

	// +-177 maps to +-180 deg, positive when v leads i
	parameter int THETA_W = 9;

	typedef logic signed [THETA_W-1:0] theta_t;

	// one estimate per switching period
	typedef struct packed {
		logic valid;
		theta_t theta;
	} phase_sample_t;

	// |theta|, -256 still comes out right as unsigned
	function automatic logic [THETA_W-1:0] theta_mag(input theta_t t);
		return t[THETA_W-1] ? THETA_W'(-t) : THETA_W'(t);
	endfunction

endpackage

`default_nettype wire

/* design/control_types_pkg.sv */
`default_nettype none

package control_types_pkg;

	// oscillator frequency word width
	parameter int FREQ_W = 15;

	// increment fed to the current-controlled oscillator
	typedef logic [FREQ_W-1:0] freq_word_t;

	// strobes are one clock wide
	// ctrl_phase is a level, toggled per control strobe
	typedef struct packed {
		logic avg_tick;
		logic lock_tick;
		logic ctrl_tick;
		logic ctrl_phase;
	} tick_bus_t;

endpackage

`default_nettype wire

/* design/rate_tick_gen.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rfo_defs.svh"

module rate_tick_gen (
	input wire logic clk10MHz_inv,
	input wire logic rst_n,
	output control_types_pkg::tick_bus_t ticks
);

	// prescaler runs at the averaging rate, slots count averaging periods
	localparam int PRE_W = $clog2(`RFO_AVG_DIV);
	localparam int LOCK_SLOTS = `RFO_LOCK_DIV / `RFO_AVG_DIV;
	localparam int CTRL_SLOTS = `RFO_CTRL_DIV / `RFO_AVG_DIV;
	localparam int SLOT_W = $clog2(CTRL_SLOTS);

	logic [PRE_W-1:0] pre_cnt;
	logic [SLOT_W-1:0] slot_cnt;
	logic pre_wrap;
	logic lock_slot;
	logic ctrl_slot;

	assign pre_wrap = (pre_cnt == PRE_W'(`RFO_AVG_DIV - 1));
	// lock every LOCK_SLOTS-th slot, control on the last one
	assign lock_slot = (slot_cnt % SLOT_W'(LOCK_SLOTS)) == SLOT_W'(LOCK_SLOTS - 1);
	assign ctrl_slot = (slot_cnt == SLOT_W'(CTRL_SLOTS - 1));

	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			pre_cnt <= '0;
			slot_cnt <= '0;
			ticks <= '0;
		end else begin
			// strobes registered, so exactly one clock wide
			ticks.avg_tick <= pre_wrap;
			ticks.lock_tick <= pre_wrap & lock_slot;
			ticks.ctrl_tick <= pre_wrap & ctrl_slot;
			// slow dither square wave
			if (ticks.ctrl_tick) begin
				ticks.ctrl_phase <= ~ticks.ctrl_phase;
			end
			if (pre_wrap) begin
				pre_cnt <= '0;
				slot_cnt <= ctrl_slot ? '0 : slot_cnt + 1'b1;
			end else begin
				pre_cnt <= pre_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/iq_delay_line.sv */
`timescale 1ns/10ps
`default_nettype none

module iq_delay_line #(
	parameter int DEPTH = 256,
	parameter int PHASE_TAP = 37,
	parameter int QUAD_TAP = 79
) (
	input wire logic clk10MHz_inv,
	input wire logic rst_n,
	input wire logic iq,
	output logic iq_inphase,
	output logic iq_quad
);

	// index wraps by overflow, so DEPTH is a power of two
	localparam int AW = $clog2(DEPTH);

	logic [DEPTH-1:0] line_q;
	logic [AW-1:0] wr_idx;
	logic [AW-1:0] rd_phase;
	logic [AW-1:0] rd_quad;

	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			wr_idx <= '0;
		end else begin
			wr_idx <= wr_idx + 1'b1;
		end
	end

	// newest sample goes in at the write index
	always_ff @(posedge clk10MHz_inv) begin
		line_q[wr_idx] <= iq;
	end

	// wr_idx already points past the newest entry,
	// so a tap of K reads iq from exactly K clocks back
	assign rd_phase = wr_idx - AW'(PHASE_TAP);
	assign rd_quad = wr_idx - AW'(QUAD_TAP);

	assign iq_inphase = line_q[rd_phase];
	assign iq_quad = line_q[rd_quad];

endmodule

`default_nettype wire

/* design/phase_estimator.sv */
`timescale 1ns/10ps
`default_nettype none

module phase_estimator (
	input wire logic clk10MHz_inv,
	input wire logic rst_n,
	input wire logic cycle,
	input wire logic iq_inphase,
	input wire logic iq_quad,
	output phase_types_pkg::phase_sample_t phase_sample
);

	import phase_types_pkg::*;

	logic cycle_meta;
	logic cycle_sync;
	logic cycle_prev;
	logic period_start;
	logic primed_q;
	// 9 bits covers periods up to 511 clocks
	logic [THETA_W-1:0] coin_cnt;
	logic signed [THETA_W-1:0] quad_cnt;
	logic [THETA_W-1:0] magnitude;
	theta_t theta_next;

	// two-flop sync plus a third flop for the edge
	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			cycle_meta <= 1'b0;
			cycle_sync <= 1'b0;
			cycle_prev <= 1'b0;
		end else begin
			cycle_meta <= cycle;
			cycle_sync <= cycle_meta;
			cycle_prev <= cycle_sync;
		end
	end

	// rising edge of cycle seen two clocks late
	assign period_start = cycle_sync & ~cycle_prev;

	// count scaled by 17/16 so a full period of 167 reads 177
	assign magnitude = coin_cnt + {4'b0, coin_cnt[THETA_W-1:4]};
	// quadrature count tells which side of zero
	assign theta_next = quad_cnt[THETA_W-1] ? theta_t'(-$signed(magnitude))
	                                        : theta_t'(magnitude);

	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			coin_cnt <= '0;
			quad_cnt <= '0;
			primed_q <= 1'b0;
			phase_sample <= '0;
		end else if (period_start) begin
			// first start only opens a period with nothing to report
			phase_sample.valid <= primed_q;
			phase_sample.theta <= theta_next;
			primed_q <= 1'b1;
			coin_cnt <= '0;
			quad_cnt <= '0;
		end else begin
			phase_sample.valid <= 1'b0;
			// in-phase coincidence
			if (cycle_sync == iq_inphase) begin
				coin_cnt <= coin_cnt + 1'b1;
			end
			// up/down against the quarter period tap
			if (cycle_sync == iq_quad) begin
				quad_cnt <= quad_cnt + 2'sd1;
			end else begin
				quad_cnt <= quad_cnt - 2'sd1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/theta_smoother.sv */
`timescale 1ns/10ps
`default_nettype none

module theta_smoother (
	input wire logic clk10MHz_inv,
	input wire logic rst_n,
	input wire phase_types_pkg::phase_sample_t phase_sample,
	input wire control_types_pkg::tick_bus_t ticks,
	output phase_types_pkg::theta_t theta_smooth
);

	import phase_types_pkg::*;

	// seven old values plus the newest make eight
	localparam int HIST = 7;

	theta_t latest_q;
	theta_t hist_q [HIST];
	logic signed [THETA_W+2:0] sum;

	// sign-extended sum of all eight
	always_comb begin
		sum = (THETA_W + 3)'(latest_q);
		for (int i = 0; i < HIST; i++) begin
			sum = sum + (THETA_W + 3)'(hist_q[i]);
		end
	end

	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			latest_q <= '0;
			hist_q <= '{default: '0};
			theta_smooth <= '0;
		end else begin
			// hold newest estimate until the next strobe
			if (phase_sample.valid) begin
				latest_q <= phase_sample.theta;
			end
			if (ticks.avg_tick) begin
				hist_q[0] <= latest_q;
				for (int i = 1; i < HIST; i++) begin
					hist_q[i] <= hist_q[i-1];
				end
				// divide by 8, rounds toward minus infinity
				theta_smooth <= theta_t'(sum >>> 3);
			end
		end
	end

endmodule

`default_nettype wire

/* design/lock_detector.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rfo_defs.svh"

module lock_detector (
	input wire logic clk10MHz_inv,
	input wire logic rst_n,
	input wire phase_types_pkg::theta_t theta_smooth,
	input wire control_types_pkg::tick_bus_t ticks,
	input wire logic standby,
	output logic locked
);

	import phase_types_pkg::*;

	logic [THETA_W-1:0] magnitude;
	logic below_limit;
	logic locked_q;

	assign magnitude = theta_mag(theta_smooth);

	// wide window while locked, narrow one to get there
	assign below_limit = locked_q ? (magnitude < THETA_W'(`RFO_LOCK_UPPER))
	                              : (magnitude < THETA_W'(`RFO_LOCK_LOWER));

	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			locked_q <= 1'b0;
		end else if (standby) begin
			locked_q <= 1'b0;
		end else if (ticks.lock_tick) begin
			locked_q <= below_limit;
		end
	end

	// standby drops the flag right away
	assign locked = locked_q & ~standby;

endmodule

`default_nettype wire

/* design/pi_freq_control.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rfo_defs.svh"

module pi_freq_control (
	input wire logic clk10MHz_inv,
	input wire logic rst_n,
	input wire phase_types_pkg::theta_t theta_smooth,
	input wire control_types_pkg::tick_bus_t ticks,
	output control_types_pkg::freq_word_t freq_increment
);

	import phase_types_pkg::*;
	import control_types_pkg::*;

	// two fraction bits below the frequency word
	localparam int ACC_W = FREQ_W + 2;

	logic [THETA_W-1:0] magnitude;
	logic [THETA_W-1:0] prev_mag;
	logic signed [THETA_W:0] delta;
	logic [ACC_W-1:0] accum;
	freq_word_t dither;

	assign magnitude = theta_mag(theta_smooth);

	// positive when |theta| shrank since the last strobe
	assign delta = $signed({1'b0, prev_mag}) - $signed({1'b0, magnitude});

	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			prev_mag <= '0;
			accum <= ACC_W'(`RFO_START_POINT * 4);
		end else if (ticks.ctrl_tick) begin
			prev_mag <= magnitude;
			// gain of two on delta, half a step per count at the output
			accum <= accum + {{(ACC_W - THETA_W - 2){delta[THETA_W]}}, delta, 1'b0};
		end
	end

	// square-wave dither around the integrator
	assign dither = ticks.ctrl_phase ? freq_word_t'(`RFO_DITHER_STEP) : '0;

	// drop the fraction bits
	assign freq_increment = accum[ACC_W-1:2] + dither;

endmodule

`default_nettype wire

/* design/rfo_phase_lock.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rfo_defs.svh"

module rfo_phase_lock (
	input wire logic clk10MHz_inv,
	input wire logic rst_n,
	input wire logic cycle,
	input wire logic iq,
	input wire logic standby,
	output phase_types_pkg::phase_sample_t phase_sample,
	output phase_types_pkg::theta_t theta_smooth,
	output logic locked,
	output control_types_pkg::freq_word_t freq_increment
);

	import control_types_pkg::*;

	tick_bus_t ticks;
	logic iq_inphase;
	logic iq_quad;

	// averaging, lock and control strobes
	rate_tick_gen i_rate_tick_gen (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.ticks        (ticks)
	);

	// iq taps for in-phase and quadrature compare
	iq_delay_line #(
		.DEPTH     (`RFO_DELAY_DEPTH),
		.PHASE_TAP (`RFO_PHASE_TAP),
		.QUAD_TAP  (`RFO_QUAD_TAP)
	) i_iq_delay_line (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.iq           (iq),
		.iq_inphase   (iq_inphase),
		.iq_quad      (iq_quad)
	);

	// one angle per switching period
	phase_estimator i_phase_estimator (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.cycle        (cycle),
		.iq_inphase   (iq_inphase),
		.iq_quad      (iq_quad),
		.phase_sample (phase_sample)
	);

	theta_smoother i_theta_smoother (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.phase_sample (phase_sample),
		.ticks        (ticks),
		.theta_smooth (theta_smooth)
	);

	lock_detector i_lock_detector (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.theta_smooth (theta_smooth),
		.ticks        (ticks),
		.standby      (standby),
		.locked       (locked)
	);

	// frequency word back to the oscillator
	pi_freq_control i_pi_freq_control (
		.clk10MHz_inv   (clk10MHz_inv),
		.rst_n          (rst_n),
		.theta_smooth   (theta_smooth),
		.ticks          (ticks),
		.freq_increment (freq_increment)
	);

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic clk10MHz_inv,
	output logic rst_n
);

	// free-running clock, starts low
	initial begin
		clk10MHz_inv = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk10MHz_inv = ~clk10MHz_inv;
		end
	end

	// released just after an edge, like every other input
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk10MHz_inv);
		#5 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* verif/rfo_phase_lock_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rfo_defs.svh"

module rfo_phase_lock_tb;

	import phase_types_pkg::*;
	import control_types_pkg::*;

	// switching period of cycle in clocks
	localparam int PERIOD_CLKS = 166;
	localparam int HALF_CLKS = PERIOD_CLKS / 2;
	// cycle reaches the estimator two clocks late
	// so iq leading by PHASE_TAP - 2 lines up with the in-phase tap
	localparam int ALIGN_OFF = PERIOD_CLKS - (`RFO_PHASE_TAP - 2);
	// deep enough for the quad tap plus sync delay
	localparam int HIST_LEN = `RFO_QUAD_TAP + 8;
	localparam int WARM_CLKS = 100;
	localparam int JITTER_CLKS = 20 * PERIOD_CLKS;
	// eight averaging strobes to flush then one control strobe
	localparam int SETTLE_CLKS = 70000;
	// just over one dither half period
	localparam int CHECK_CLKS = 33000;
	localparam int HOLD_CLKS = SETTLE_CLKS + CHECK_CLKS;
	localparam int TEST_CLKS = WARM_CLKS + JITTER_CLKS + 4 * HOLD_CLKS + SETTLE_CLKS;
	localparam int TIMEOUT_CLKS = TEST_CLKS * 12 / 10;

	logic clk10MHz_inv;
	logic rst_n;
	logic cycle;
	logic iq;
	logic standby;
	phase_sample_t phase_sample;
	theta_t theta_smooth;
	logic locked;
	freq_word_t freq_increment;

	// stimulus state
	string test_name = "reset";
	logic running = 1'b0;
	logic jitter_on = 1'b0;
	logic iq_invert = 1'b0;
	int iq_offset = 0;
	int phase_cnt = PERIOD_CLKS - 1;
	logic cyc_hist[$];
	logic iq_hist[$];

	// reference model state
	logic model_on = 1'b0;
	logic m_primed = 1'b0;
	int m_coin = 0;
	int m_quad = 0;
	logic exp_valid = 1'b0;
	int exp_theta = 0;
	int last_theta = 0;

	// check enables and settled expectations
	logic chk_reset = 1'b0;
	logic chk_smooth = 1'b0;
	logic chk_lock_hi = 1'b0;
	logic chk_lock_lo = 1'b0;
	int smooth_exp = 0;
	int freq_low_exp = 0;
	logic seen_low = 1'b0;
	logic seen_high = 1'b0;
	int cycle_count = 0;

	tb_clock_gen #(
		.PERIOD_NS    (100),
		.RESET_CYCLES (2)
	) i_tb_clock_gen (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n)
	);

	rfo_phase_lock i_rfo_phase_lock (
		.clk10MHz_inv   (clk10MHz_inv),
		.rst_n          (rst_n),
		.cycle          (cycle),
		.iq             (iq),
		.standby        (standby),
		.phase_sample   (phase_sample),
		.theta_smooth   (theta_smooth),
		.locked         (locked),
		.freq_increment (freq_increment)
	);

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_error(input string check, input int expected, input int actual);
		$display("error: %s %s expected %0d actual %0d", test_name, check, expected, actual);
		stop_run();
	endtask

	task automatic report_fault(input string what);
		$display("error: %s %s", test_name, what);
		stop_run();
	endtask

	// square wave high for the first half of each period
	function automatic logic square_at(input int pos);
		int p;
		p = pos % PERIOD_CLKS;
		if (p < 0) begin
			p = p + PERIOD_CLKS;
		end
		return p < HALF_CLKS;
	endfunction

	// coincidence count scaled by 17/16 with sign from the quad count
	function automatic int angle_rule(input int coin, input int quad);
		int mag;
		mag = coin + coin / 16;
		return (quad < 0) ? -mag : mag;
	endfunction

	task automatic update_model();
		logic sync_now;
		logic sync_prev;
		// synced cycle in the interval before this edge
		sync_now = cyc_hist[3];
		sync_prev = cyc_hist[4];
		if (sync_now && !sync_prev) begin
			exp_valid = m_primed;
			exp_theta = angle_rule(m_coin, m_quad);
			if (m_primed) begin
				last_theta = exp_theta;
			end
			m_primed = 1'b1;
			m_coin = 0;
			m_quad = 0;
		end else begin
			exp_valid = 1'b0;
			// taps one deeper than their distance for the same interval
			if (sync_now == iq_hist[`RFO_PHASE_TAP + 1]) begin
				m_coin = m_coin + 1;
			end
			if (sync_now == iq_hist[`RFO_QUAD_TAP + 1]) begin
				m_quad = m_quad + 1;
			end else begin
				m_quad = m_quad - 1;
			end
		end
	endtask

	// one clock of stimulus driven 5 ns after the edge
	task automatic clock_step();
		logic iq_bit;
		logic drop;
		@(posedge clk10MHz_inv);
		#5;
		if (running) begin
			phase_cnt = (phase_cnt + 1) % PERIOD_CLKS;
		end
		iq_bit = iq_invert ^ square_at(phase_cnt - iq_offset);
		// occasional random bit on iq
		if (jitter_on && ($urandom % 8) == 0) begin
			iq_bit = 1'($urandom);
		end
		cycle = running ? square_at(phase_cnt) : 1'b0;
		iq = running ? iq_bit : 1'b0;
		cyc_hist.push_front(cycle);
		iq_hist.push_front(iq);
		drop = cyc_hist.pop_back();
		drop = iq_hist.pop_back();
		update_model();
	endtask

	task automatic run_clocks(input int n);
		repeat (n) clock_step();
	endtask

	// hold one offset then check smoothing, freq word and lock
	task automatic hold_angle(input string name, input int offset, input logic invert,
	                          input int lock_mode);
		test_name = name;
		iq_offset = offset;
		iq_invert = invert;
		run_clocks(SETTLE_CLKS);
		smooth_exp = last_theta;
		// integrator telescopes to -|theta| from prev_mag of 0
		// two per count over two fraction bits gives the floor of half
		freq_low_exp = `RFO_START_POINT - (((last_theta < 0) ? -last_theta : last_theta) + 1) / 2;
		seen_low = 1'b0;
		seen_high = 1'b0;
		chk_smooth = 1'b1;
		if (lock_mode == 1) begin
			chk_lock_hi = 1'b1;
		end
		if (lock_mode == 2) begin
			chk_lock_lo = 1'b1;
		end
		run_clocks(CHECK_CLKS);
		chk_smooth = 1'b0;
		assert (seen_low && seen_high)
			else report_fault("frequency word did not show both dither values");
	endtask

	// dither values seen mid-cycle where outputs are stable
	always @(negedge clk10MHz_inv) begin
		if (chk_smooth) begin
			if (freq_increment == freq_word_t'(freq_low_exp)) begin
				seen_low = 1'b1;
			end
			if (freq_increment == freq_word_t'(freq_low_exp + `RFO_DITHER_STEP)) begin
				seen_high = 1'b1;
			end
		end
	end

	// state straight out of reset
	assert property (@(posedge clk10MHz_inv)
		!chk_reset || freq_increment == freq_word_t'(`RFO_START_POINT))
		else value_error("reset freq", `RFO_START_POINT, $sampled(freq_increment));
	assert property (@(posedge clk10MHz_inv)
		!chk_reset || (!locked && !phase_sample.valid))
		else value_error("reset lock and valid", 0,
		                 {$sampled(locked), $sampled(phase_sample.valid)});

	// every period estimate against the model
	assert property (@(posedge clk10MHz_inv) !model_on || phase_sample.valid == exp_valid)
		else value_error("sample valid", exp_valid, $sampled(phase_sample.valid));
	assert property (@(posedge clk10MHz_inv)
		!model_on || !exp_valid || phase_sample.theta == theta_t'(exp_theta))
		else value_error("sample theta", exp_theta, $sampled(phase_sample.theta));

	// settled average within one count
	assert property (@(posedge clk10MHz_inv)
		!chk_smooth || (int'(theta_smooth) >= smooth_exp - 1 &&
		                int'(theta_smooth) <= smooth_exp + 1))
		else value_error("smoothed theta", smooth_exp, $sampled(theta_smooth));

	// integrator plus dither gives only two values
	assert property (@(posedge clk10MHz_inv)
		!chk_smooth || freq_increment == freq_word_t'(freq_low_exp) ||
		freq_increment == freq_word_t'(freq_low_exp + `RFO_DITHER_STEP))
		else value_error("freq word", freq_low_exp, $sampled(freq_increment));

	assert property (@(posedge clk10MHz_inv) !chk_lock_hi || locked)
		else value_error("locked", 1, $sampled(locked));
	assert property (@(posedge clk10MHz_inv) !chk_lock_lo || !locked)
		else value_error("locked", 0, $sampled(locked));
	assert property (@(posedge clk10MHz_inv) !(standby && locked))
		else value_error("locked in standby", 0, $sampled(locked));

	always @(posedge clk10MHz_inv) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CLKS) begin
			report_fault("run exceeded its cycle limit without finishing");
		end
	end

	initial begin
		void'($urandom(32'h926a_c95c));
		cycle = 1'b0;
		iq = 1'b0;
		standby = 1'b0;
		repeat (HIST_LEN) begin
			cyc_hist.push_back(1'b0);
			iq_hist.push_back(1'b0);
		end
		@(posedge rst_n);
		model_on = 1'b1;
		chk_reset = 1'b1;
		run_clocks(WARM_CLKS);
		chk_reset = 1'b0;
		// noisy iq with every sample checked
		test_name = "jitter";
		running = 1'b1;
		iq_offset = 50;
		jitter_on = 1'b1;
		run_clocks(JITTER_CLKS);
		jitter_on = 1'b0;
		// large negative angle
		hold_angle("smooth", 0, 1'b0, 0);
		// zero angle so lock expected
		hold_angle("lock_zero", ALIGN_OFF, 1'b1, 1);
		// about 25 and lock held through the whole move
		hold_angle("lock_mid", ALIGN_OFF + 12, 1'b1, 1);
		chk_lock_hi = 1'b0;
		// about 46 so lock is lost
		hold_angle("lock_far", ALIGN_OFF + 22, 1'b1, 2);
		chk_lock_lo = 1'b0;
		// zero angle again while standby keeps lock off
		test_name = "standby";
		standby = 1'b1;
		iq_offset = ALIGN_OFF;
		chk_lock_lo = 1'b1;
		run_clocks(SETTLE_CLKS);
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* rfo_phase_lock.f */
+incdir+design
design/phase_types_pkg.sv
design/control_types_pkg.sv
design/rate_tick_gen.sv
design/iq_delay_line.sv
design/phase_estimator.sv
design/theta_smoother.sv
design/lock_detector.sv
design/pi_freq_control.sv
design/rfo_phase_lock.sv
verif/tb_clock_gen.sv
verif/rfo_phase_lock_tb.sv
